/* bp_frontend.f */
+incdir+verif
hw/bp_pkg.sv
hw/bp_table.sv
hw/bp_fetch_stage.sv
hw/bp_resolve_stage.sv
hw/bp_frontend_top.sv
verif/bp_frontend_tb.sv

/* hw/bp_fetch_stage.sv */
`timescale 1ns/10ps

module bp_fetch_stage (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             fetch_valid_i,
    input  bp_pkg::pc_addr_u fetch_pc_i,

    output bp_pkg::pc_addr_u rd_pc_0_o,
    output bp_pkg::pc_addr_u rd_pc_1_o,
    input  logic             rd_hit_0_i,
    input  logic [31:0]      rd_target_0_i,
    input  logic             rd_hit_1_i,
    input  logic [31:0]      rd_target_1_i,

    output logic             pred_valid_o,
    output logic             pred_taken_o,
    output logic             pred_slot_o,
    output logic [31:0]      pred_target_o
);

    logic        taken_nxt;
    logic        slot_nxt;
    logic [31:0] target_nxt;

    // ############################################################
    // Bundle lookup
    // ############################################################

    always_comb begin
        rd_pc_0_o     = fetch_pc_i;
        rd_pc_1_o.raw = fetch_pc_i.raw + 32'd4;                           // Second slot of the bundle.
    end

    // Slot 0 wins when both slots hit.
    always_comb begin
        taken_nxt  = rd_hit_0_i | rd_hit_1_i;
        slot_nxt   = ~rd_hit_0_i;
        target_nxt = '0;
        if (rd_hit_0_i) begin
            target_nxt = rd_target_0_i;
        end else if (rd_hit_1_i) begin
            target_nxt = rd_target_1_i;
        end
    end

    // ############################################################
    // Prediction register
    // ############################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            pred_taken_o  <= taken_nxt;
            pred_slot_o   <= slot_nxt;
            pred_target_o <= target_nxt;
        end
    end

endmodule

/* hw/bp_frontend_top.sv */
`timescale 1ns/10ps

module bp_frontend_top (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             fetch_valid_i,
    input  bp_pkg::pc_addr_u fetch_pc_i,
    output logic             pred_valid_o,
    output logic             pred_taken_o,
    output logic             pred_slot_o,
    output logic [31:0]      pred_target_o,

    input  logic             res_valid_i,
    input  bp_pkg::pc_addr_u res_pc_i,
    input  logic             res_taken_i,
    input  logic [31:0]      res_target_i,
    input  logic             res_pred_taken_i,
    input  logic [31:0]      res_pred_target_i,
    output logic             mispredict_o,
    output logic [31:0]      redirect_pc_o
);

    bp_pkg::pc_addr_u rd_pc_0;
    bp_pkg::pc_addr_u rd_pc_1;
    logic             rd_hit_0;
    logic [31:0]      rd_target_0;
    logic             rd_hit_1;
    logic [31:0]      rd_target_1;

    logic             upd_valid;
    bp_pkg::pc_addr_u upd_pc;
    logic             upd_taken;
    logic [31:0]      upd_target;

    bp_fetch_stage bp_fetch_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .rd_pc_0_o     (rd_pc_0),
        .rd_pc_1_o     (rd_pc_1),
        .rd_hit_0_i    (rd_hit_0),
        .rd_target_0_i (rd_target_0),
        .rd_hit_1_i    (rd_hit_1),
        .rd_target_1_i (rd_target_1),
        .pred_valid_o  (pred_valid_o),
        .pred_taken_o  (pred_taken_o),
        .pred_slot_o   (pred_slot_o),
        .pred_target_o (pred_target_o)
    );

    bp_table bp_table_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_pc_0_i     (rd_pc_0),
        .rd_pc_1_i     (rd_pc_1),
        .rd_hit_0_o    (rd_hit_0),
        .rd_target_0_o (rd_target_0),
        .rd_hit_1_o    (rd_hit_1),
        .rd_target_1_o (rd_target_1),
        .upd_valid_i   (upd_valid),
        .upd_pc_i      (upd_pc),
        .upd_taken_i   (upd_taken),
        .upd_target_i  (upd_target)
    );

    bp_resolve_stage bp_resolve_stage_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .res_valid_i       (res_valid_i),
        .res_pc_i          (res_pc_i),
        .res_taken_i       (res_taken_i),
        .res_target_i      (res_target_i),
        .res_pred_taken_i  (res_pred_taken_i),
        .res_pred_target_i (res_pred_target_i),
        .upd_valid_o       (upd_valid),
        .upd_pc_o          (upd_pc),
        .upd_taken_o       (upd_taken),
        .upd_target_o      (upd_target),
        .mispredict_o      (mispredict_o),
        .redirect_pc_o     (redirect_pc_o)
    );

endmodule

/* hw/bp_pkg.sv */
package bp_pkg;

    // ############################################################
    // Table geometry
    // ############################################################

    localparam int NUM_PC_BIT     = 32;
    localparam int NUM_INDEX_BIT  = 4;
    localparam int NUM_ENTRY      = 1 << NUM_INDEX_BIT;
    localparam int NUM_OFFSET_BIT = 2;                                     // Word aligned fetch.
    localparam int NUM_TAG_BIT    = NUM_PC_BIT - NUM_INDEX_BIT - NUM_OFFSET_BIT;

    // ############################################################
    // Two-bit saturating counter states
    // ############################################################

    localparam logic [1:0] S_NONTAKEN      = 2'd0;
    localparam logic [1:0] S_NEAR_NONTAKEN = 2'd1;                         // Reset state.
    localparam logic [1:0] S_NEAR_TAKEN    = 2'd2;
    localparam logic [1:0] S_TAKEN         = 2'd3;

    // ############################################################
    // Program counter as a raw word or as lookup fields
    // ############################################################

    typedef union packed {
        logic [NUM_PC_BIT-1:0] raw;
        struct packed {
            logic [NUM_TAG_BIT-1:0]    tag;                                // Not checked in this table.
            logic [NUM_INDEX_BIT-1:0]  index;
            logic [NUM_OFFSET_BIT-1:0] offset;
        } field;
    } pc_addr_u;

endpackage

/* hw/bp_resolve_stage.sv */
`timescale 1ns/10ps

module bp_resolve_stage (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             res_valid_i,
    input  bp_pkg::pc_addr_u res_pc_i,
    input  logic             res_taken_i,
    input  logic [31:0]      res_target_i,
    input  logic             res_pred_taken_i,
    input  logic [31:0]      res_pred_target_i,

    output logic             upd_valid_o,
    output bp_pkg::pc_addr_u upd_pc_o,
    output logic             upd_taken_o,
    output logic [31:0]      upd_target_o,

    output logic             mispredict_o,
    output logic [31:0]      redirect_pc_o
);

    logic        dir_miss;
    logic        target_miss;
    logic        miss;
    logic        miss_q;
    logic [31:0] redirect_nxt;

    // ############################################################
    // Miss rule and redirect address
    // ############################################################

    assign dir_miss    = res_taken_i != res_pred_taken_i;
    assign target_miss = res_taken_i && res_pred_taken_i && (res_target_i != res_pred_target_i);
    assign miss        = res_valid_i && (dir_miss || target_miss);

    always_comb begin
        if (res_taken_i) begin
            redirect_nxt = {res_target_i[31:2], 2'b00};
        end else begin
            redirect_nxt = res_pc_i.raw + 32'd4;                          // Fall through.
        end
    end

    // ############################################################
    // Update and redirect registers
    // ############################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miss_q <= 1'b0;
        end else begin
            miss_q <= miss;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            upd_pc_o      <= res_pc_i;
            upd_taken_o   <= res_taken_i;
            upd_target_o  <= res_target_i;                                // The table aligns it.
            redirect_pc_o <= redirect_nxt;
        end
    end

    // A table write is exactly a miss.
    assign upd_valid_o  = miss_q;
    assign mispredict_o = miss_q;

endmodule

/* hw/bp_table.sv */
`timescale 1ns/10ps

module bp_table (
    input  logic             clk,
    input  logic             rst_n,

    input  bp_pkg::pc_addr_u rd_pc_0_i,
    input  bp_pkg::pc_addr_u rd_pc_1_i,
    output logic             rd_hit_0_o,
    output logic [31:0]      rd_target_0_o,
    output logic             rd_hit_1_o,
    output logic [31:0]      rd_target_1_o,

    input  logic             upd_valid_i,
    input  bp_pkg::pc_addr_u upd_pc_i,
    input  logic             upd_taken_i,
    input  logic [31:0]      upd_target_i
);

    logic [1:0]  counter [bp_pkg::NUM_ENTRY];
    logic [31:0] target  [bp_pkg::NUM_ENTRY];

    logic [bp_pkg::NUM_INDEX_BIT-1:0] rd_index_0;
    logic [bp_pkg::NUM_INDEX_BIT-1:0] rd_index_1;
    logic [bp_pkg::NUM_INDEX_BIT-1:0] upd_index;

    logic [1:0] counter_cur;
    logic [1:0] counter_nxt;

    function automatic logic is_hit(input logic [1:0] state);
        return (state == bp_pkg::S_NEAR_TAKEN) || (state == bp_pkg::S_TAKEN);
    endfunction

    // ############################################################
    // Read ports
    // ############################################################

    assign rd_index_0 = rd_pc_0_i.field.index;
    assign rd_index_1 = rd_pc_1_i.field.index;

    assign rd_hit_0_o    = is_hit(counter[rd_index_0]);
    assign rd_hit_1_o    = is_hit(counter[rd_index_1]);
    assign rd_target_0_o = target[rd_index_0];
    assign rd_target_1_o = target[rd_index_1];

    // ############################################################
    // Counter step toward the resolved direction
    // ############################################################

    assign upd_index   = upd_pc_i.field.index;
    assign counter_cur = counter[upd_index];

    always_comb begin
        counter_nxt = counter_cur;
        if (upd_taken_i) begin
            case (counter_cur)
                bp_pkg::S_NONTAKEN: begin
                    counter_nxt = bp_pkg::S_NEAR_NONTAKEN;
                end
                bp_pkg::S_NEAR_NONTAKEN: begin
                    counter_nxt = bp_pkg::S_NEAR_TAKEN;
                end
                default: begin
                    counter_nxt = bp_pkg::S_TAKEN;                         // Saturates at the top.
                end
            endcase
        end else begin
            case (counter_cur)
                bp_pkg::S_TAKEN: begin
                    counter_nxt = bp_pkg::S_NEAR_TAKEN;
                end
                bp_pkg::S_NEAR_TAKEN: begin
                    counter_nxt = bp_pkg::S_NEAR_NONTAKEN;
                end
                default: begin
                    counter_nxt = bp_pkg::S_NONTAKEN;                      // Saturates at the bottom.
                end
            endcase
        end
    end

    // ############################################################
    // Table state
    // ############################################################

    // The resolve stage only raises upd_valid_i on a miss.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < bp_pkg::NUM_ENTRY; i++) begin
                counter[i] <= bp_pkg::S_NEAR_NONTAKEN;
            end
        end else if (upd_valid_i) begin
            counter[upd_index] <= counter_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < bp_pkg::NUM_ENTRY; i++) begin
                target[i] <= '0;
            end
        end else if (upd_valid_i && upd_taken_i) begin
            target[upd_index] <= {upd_target_i[31:2], 2'b00};              // Stored word aligned.
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module bp_frontend_tb -f bp_frontend.f -o bp_frontend_sim

./obj_dir/bp_frontend_sim > sim.log
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* verif/bp_model.svh */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// Reference model of the predictor that the testbench steps once per clock cycle.

logic [1:0]                       m_counter [bp_pkg::NUM_ENTRY];
bp_pkg::pc_addr_u                 m_target  [bp_pkg::NUM_ENTRY];
logic                             m_upd_valid;
logic [bp_pkg::NUM_INDEX_BIT-1:0] m_upd_index;
logic                             m_upd_taken;
bp_pkg::pc_addr_u                 m_upd_target;

function automatic void reset_table_model();
    for (int i = 0; i < bp_pkg::NUM_ENTRY; i++) begin
        m_counter[i] = bp_pkg::S_NEAR_NONTAKEN;
        m_target[i]  = '0;
    end
    m_upd_valid = 1'b0;
endfunction

function automatic void predict_bundle(input bp_pkg::pc_addr_u pc, output logic taken,
                                       output logic slot, output bp_pkg::pc_addr_u target);
    bp_pkg::pc_addr_u pc_next;
    logic             hit_0;
    logic             hit_1;
    pc_next.raw = pc.raw + 32'd4;
    hit_0  = m_counter[pc.field.index] >= bp_pkg::S_NEAR_TAKEN;
    hit_1  = m_counter[pc_next.field.index] >= bp_pkg::S_NEAR_TAKEN;
    taken  = hit_0 || hit_1;
    slot   = !hit_0;                                                     // Slot 0 has priority.
    target = '0;
    if (hit_0) begin
        target = m_target[pc.field.index];
    end else if (hit_1) begin
        target = m_target[pc_next.field.index];
    end
endfunction

function automatic void evaluate_resolve(input bp_pkg::pc_addr_u pc, input logic taken,
                                         input bp_pkg::pc_addr_u target, input logic pred_taken,
                                         input bp_pkg::pc_addr_u pred_target, output logic miss,
                                         output bp_pkg::pc_addr_u redirect);
    miss = (taken != pred_taken) || (taken && pred_taken && (target.raw != pred_target.raw));
    if (taken) begin
        redirect.raw = target.raw & 32'hffff_fffc;
    end else begin
        redirect.raw = pc.raw + 32'd4;
    end
endfunction

// The previous cycle's miss lands in the table now, this cycle's miss one cycle later.
function automatic void commit_update(input logic miss, input bp_pkg::pc_addr_u pc,
                                      input logic taken, input bp_pkg::pc_addr_u target);
    if (m_upd_valid) begin
        if (m_upd_taken && (m_counter[m_upd_index] != bp_pkg::S_TAKEN)) begin
            m_counter[m_upd_index] = m_counter[m_upd_index] + 2'd1;
        end else if (!m_upd_taken && (m_counter[m_upd_index] != bp_pkg::S_NONTAKEN)) begin
            m_counter[m_upd_index] = m_counter[m_upd_index] - 2'd1;
        end
        if (m_upd_taken) begin
            m_target[m_upd_index].raw = m_upd_target.raw & 32'hffff_fffc;
        end
    end
    m_upd_valid  = miss;
    m_upd_index  = pc.field.index;
    m_upd_taken  = taken;
    m_upd_target = target;
endfunction

`endif

/* verif/bp_frontend_tb.sv */
`timescale 1ns/10ps

module bp_frontend_tb;

    localparam int NUM_RANDOM    = 2000;
    localparam int NUM_DIRECTED  = 150;                                  // Upper bound of directed cycles.
    localparam int WATCHDOG_NS   = (NUM_RANDOM + NUM_DIRECTED + 20) * 8;

    logic             clk;
    logic             rst_n;
    logic             fetch_valid_i;
    bp_pkg::pc_addr_u fetch_pc_i;
    logic             pred_valid_o;
    logic             pred_taken_o;
    logic             pred_slot_o;
    logic [31:0]      pred_target_o;
    logic             res_valid_i;
    bp_pkg::pc_addr_u res_pc_i;
    logic             res_taken_i;
    bp_pkg::pc_addr_u res_target_i;
    logic             res_pred_taken_i;
    bp_pkg::pc_addr_u res_pred_target_i;
    logic             mispredict_o;
    logic [31:0]      redirect_pc_o;

    int pred_errors = 0;
    int res_errors  = 0;

    `include "bp_model.svh"

    bp_frontend_top bp_frontend_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .fetch_valid_i     (fetch_valid_i),
        .fetch_pc_i        (fetch_pc_i),
        .pred_valid_o      (pred_valid_o),
        .pred_taken_o      (pred_taken_o),
        .pred_slot_o       (pred_slot_o),
        .pred_target_o     (pred_target_o),
        .res_valid_i       (res_valid_i),
        .res_pc_i          (res_pc_i),
        .res_taken_i       (res_taken_i),
        .res_target_i      (res_target_i),
        .res_pred_taken_i  (res_pred_taken_i),
        .res_pred_target_i (res_pred_target_i),
        .mispredict_o      (mispredict_o),
        .redirect_pc_o     (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // ############################################################
    // Compare tasks and stimulus helpers
    // ############################################################

    task automatic check_pred(input logic exp_taken, input logic exp_slot,
                              input bp_pkg::pc_addr_u exp_target);
        if ((pred_taken_o !== exp_taken) || (pred_slot_o !== exp_slot) ||
            (pred_target_o !== exp_target.raw)) begin
            pred_errors++;
            $display("Mismatch at %0t: prediction taken %0b slot %0b target %h, expected %0b %0b %h",
                     $time, pred_taken_o, pred_slot_o, pred_target_o,
                     exp_taken, exp_slot, exp_target.raw);
        end
    endtask

    task automatic check_resolve(input logic exp_miss, input bp_pkg::pc_addr_u exp_redirect);
        if ((mispredict_o !== exp_miss) || (exp_miss && (redirect_pc_o !== exp_redirect.raw))) begin
            res_errors++;
            $display("Mismatch at %0t: mispredict %0b redirect %h, expected %0b %h",
                     $time, mispredict_o, redirect_pc_o, exp_miss, exp_redirect.raw);
        end
    endtask

    // Drives one cycle of fetch and resolve traffic and checks the registered results.
    task automatic run_cycle(input logic fv, input bp_pkg::pc_addr_u fpc, input logic rv,
                             input bp_pkg::pc_addr_u rpc, input logic rtaken,
                             input bp_pkg::pc_addr_u rtarget, input logic ptaken,
                             input bp_pkg::pc_addr_u ptarget);
        logic             exp_taken;
        logic             exp_slot;
        bp_pkg::pc_addr_u exp_target;
        logic             exp_miss;
        bp_pkg::pc_addr_u exp_redirect;
        fetch_valid_i     = fv;
        fetch_pc_i        = fpc;
        res_valid_i       = rv;
        res_pc_i          = rpc;
        res_taken_i       = rtaken;
        res_target_i      = rtarget;
        res_pred_taken_i  = ptaken;
        res_pred_target_i = ptarget;
        predict_bundle(fpc, exp_taken, exp_slot, exp_target);
        evaluate_resolve(rpc, rtaken, rtarget, ptaken, ptarget, exp_miss, exp_redirect);
        exp_miss = exp_miss && rv;
        commit_update(exp_miss, rpc, rtaken, rtarget);
        @(posedge clk);
        #1;
        if (pred_valid_o !== fv) begin
            pred_errors++;
            $display("Mismatch at %0t: pred_valid_o %0b, expected %0b", $time, pred_valid_o, fv);
        end else if (fv) begin
            check_pred(exp_taken, exp_slot, exp_target);
        end
        check_resolve(exp_miss, exp_redirect);
    endtask

    task automatic look_up(input bp_pkg::pc_addr_u pc);
        run_cycle(1'b1, pc, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    // Resolves one branch and looks it up before and after its update lands.
    task automatic train(input bp_pkg::pc_addr_u pc, input logic taken,
                         input bp_pkg::pc_addr_u target, input logic ptaken,
                         input bp_pkg::pc_addr_u ptarget);
        run_cycle(1'b0, '0, 1'b1, pc, taken, target, ptaken, ptarget);
        look_up(pc);
        look_up(pc);
    endtask

    function automatic bp_pkg::pc_addr_u pool_pc(input int i);
        bp_pkg::pc_addr_u pc;
        if (i < 16) begin
            pc.raw = 32'h0000_1000 + 32'(i * 4);
        end else begin
            pc.raw = 32'h0004_0000 + 32'(i * 12);                        // Aliases the low indexes.
        end
        return pc;
    endfunction

    // ############################################################
    // Test sequence
    // ############################################################

    initial begin
        logic [31:0]      rnd;
        bp_pkg::pc_addr_u rtarget;
        void'($urandom(32'he1c3_00cc));
        rst_n = 1'b0;
        run_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
        reset_table_model();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if ((pred_valid_o !== 1'b0) || (mispredict_o !== 1'b0)) begin
            pred_errors++;
            $display("Mismatch at %0t: pred_valid_o %0b mispredict %0b after reset, expected 0 0",
                     $time, pred_valid_o, mispredict_o);
        end

        for (int i = 0; i < 24; i++) begin
            look_up(pool_pc(i));                                         // Fresh table predicts nothing.
        end

        // A correct not-taken resolve at S_NEAR_TAKEN would drop the hit if it wrote the table.
        train(32'h1000, 1'b1, 32'h2001, 1'b0, 32'h0);
        train(32'h1000, 1'b0, 32'h0, 1'b0, 32'h0);
        train(32'h1000, 1'b1, 32'h2000, 1'b1, 32'h2000);
        train(32'h1000, 1'b1, 32'h3000, 1'b1, 32'h2000);
        train(32'h1000, 1'b0, 32'h0, 1'b1, 32'h3000);                   // Still hits from S_TAKEN.

        for (int k = 0; k < 4; k++) begin
            train(32'h1220, 1'b0, 32'h0, 1'b1, 32'h500);
        end
        for (int k = 0; k < 6; k++) begin
            train(32'h1220, 1'b1, 32'h500, 1'b0, 32'h0);
        end
        for (int k = 0; k < 2; k++) begin
            train(32'h1220, 1'b0, 32'h0, 1'b1, 32'h500);
        end

        for (int k = 0; k < 2; k++) begin
            train(32'h1048, 1'b1, 32'h700, 1'b0, 32'h0);
            train(32'h104c, 1'b1, 32'h900, 1'b0, 32'h0);
        end
        look_up(32'h1048);                                               // Both slots hit.
        look_up(32'h1044);                                               // Only pc+4 hits.

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd = $urandom;
            rtarget.raw = pool_pc(int'(rnd[14:10]) % 24).raw | {30'd0, rnd[16:15]};
            run_cycle(rnd[1:0] != 2'd0, pool_pc(int'(rnd[9:5]) % 24), rnd[2],
                      pool_pc(int'(rnd[22:18]) % 24), rnd[3], rtarget, rnd[4],
                      rnd[17] ? rtarget : pool_pc(int'(rnd[27:23]) % 24));
        end

        $display("Prediction errors: %0d, resolve errors: %0d", pred_errors, res_errors);
        if ((pred_errors + res_errors) == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
